// File: rtl/rsse_pkg.sv
`default_nettype none

package rsse_pkg;

    // ####################
    // Datapath sizes.
    // ####################

    // Sample width for residuals, taps and static values.
    localparam int B_WIDTH = 8;

    // Symbols decided per run.
    localparam int B_LEN = 2;

    // Symbols in a reduced state.
    localparam int S_LEN = 2;

    // ####################
    // Types.
    // ####################

    // One symbol in {-1, 0, +1}.
    typedef logic signed [1:0] sym_t;

    typedef logic signed [B_WIDTH-1:0] sample_t;

    typedef logic [2*B_WIDTH-1:0] energy_t;

    // Index 0 holds the newest symbol.
    typedef sym_t [B_LEN-1:0] sym_block_t;

    typedef struct packed {
        energy_t    energy;
        sym_block_t hist;
    } state_entry_t;

    // Saturation value for path energies.
    localparam energy_t ENERGY_MAX = '1;

endpackage

`default_nettype wire

// File: rtl/conv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module conv_unit
    import rsse_pkg::*;
#(
    parameter int I_DEPTH = 18,
    parameter int F_DEPTH = 24,
    parameter int O_DEPTH = 2,
    parameter int OFFSET  = 10,
    parameter int SHIFT   = 1
) (
    input  sym_t    in     [I_DEPTH],
    input  sample_t filter [F_DEPTH],
    output sample_t out    [O_DEPTH]
);

    // Symbol times tap, then headroom for the whole sum.
    localparam int PROD_W = B_WIDTH + 2;
    localparam int ACC_W  = PROD_W + $clog2(F_DEPTH + 1);

    // One accumulator per output.
    // Output j is the branch that lies j symbols further along the history.
    for (genvar j = 0; j < O_DEPTH; j++) begin : g_out
        logic signed [ACC_W-1:0] acc;

        always_comb begin
            int                       k;
            logic signed [PROD_W-1:0] prod;
            k    = 0;
            prod = '0;
            acc  = '0;
            for (int i = 0; i < I_DEPTH; i++) begin
                // Tap aligned with history slot i.
                k = i - j + OFFSET;
                if (k >= 0 && k < F_DEPTH) begin
                    prod = in[i] * filter[k];
                    acc  = acc + ACC_W'(prod);
                end
            end
        end

        // Scale down and keep the low bits.
        assign out[j] = sample_t'(acc >>> SHIFT);
    end

endmodule

`default_nettype wire

// File: rtl/static_select_unit.sv
`timescale 1ns/1ns
`default_nettype none

module static_select_unit
    import rsse_pkg::*;
#(
    parameter int N_S = 7
) (
    input  state_entry_t states [N_S],
    output state_entry_t best
);

    localparam int IDX_W = (N_S > 1) ? $clog2(N_S) : 1;

    // Running minimum after each link of the chain.
    energy_t          min_energy [N_S];
    logic [IDX_W-1:0] min_idx    [N_S];

    // ####################
    // Compare chain.
    // ####################

    always_comb begin
        min_energy[0] = states[0].energy;
        min_idx[0]    = '0;
        for (int s = 1; s < N_S; s++) begin
            // Strict compare, so the earlier state wins a tie.
            if (states[s].energy < min_energy[s-1]) begin
                min_energy[s] = states[s].energy;
                min_idx[s]    = IDX_W'(s);
            end else begin
                min_energy[s] = min_energy[s-1];
                min_idx[s]    = min_idx[s-1];
            end
        end
    end

    // Energy and symbols of the winner travel together.
    assign best = states[min_idx[N_S-1]];

endmodule

`default_nettype wire

// File: rtl/global_static_unit.sv
`timescale 1ns/1ns
`default_nettype none

module global_static_unit
    import rsse_pkg::*;
#(
    parameter int N_S        = 7,
    parameter int H_DEPTH    = 6,
    parameter int SH_DEPTH   = 18,
    parameter int CHAN_DEPTH = 24
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         run,
    input  state_entry_t states                 [N_S],
    input  sample_t      est_channel            [CHAN_DEPTH],
    input  sample_t      rse_vals               [B_LEN],
    output energy_t      best_energy,
    output sym_block_t   final_symbols,
    output sample_t      precomputed_static_val [B_LEN],
    output energy_t      global_static_energy
);

    state_entry_t best;
    sym_t         history    [SH_DEPTH];
    sample_t      static_val [B_LEN];

    static_select_unit #(
        .N_S(N_S)
    ) u_select (
        .states(states),
        .best  (best)
    );

    // Fed back to the bank for normalization.
    assign best_energy = best.energy;

    // ####################
    // Decided history.
    // ####################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SH_DEPTH; i++) begin
                history[i] <= '0;
            end
            global_static_energy <= '0;
        end else if (run) begin
            // Older blocks move back by one block.
            for (int i = B_LEN; i < SH_DEPTH; i++) begin
                history[i] <= history[i-B_LEN];
            end
            for (int j = 0; j < B_LEN; j++) begin
                history[j] <= best.hist[j];
            end
            global_static_energy <= best.energy;
        end
    end

    always_comb begin
        for (int j = 0; j < B_LEN; j++) begin
            final_symbols[j] = history[j];
        end
    end

    // ####################
    // Static ISI.
    // ####################

    // Offset skips the block and state symbols still held in the branches.
    conv_unit #(
        .I_DEPTH(SH_DEPTH),
        .F_DEPTH(CHAN_DEPTH),
        .O_DEPTH(B_LEN),
        .OFFSET (B_LEN + H_DEPTH + S_LEN),
        .SHIFT  (1)
    ) u_conv (
        .in    (history),
        .filter(est_channel),
        .out   (static_val)
    );

    // wraps at B_WIDTH
    always_comb begin
        for (int j = 0; j < B_LEN; j++) begin
            precomputed_static_val[j] = static_val[j] + rse_vals[j];
        end
    end

endmodule

`default_nettype wire

// File: rtl/state_metric_bank.sv
`timescale 1ns/1ns
`default_nettype none

module state_metric_bank
    import rsse_pkg::*;
#(
    parameter int N_S = 7
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         run,
    input  energy_t      branch_metric [N_S],
    input  sym_block_t   new_hist      [N_S],
    input  energy_t      best_energy,
    output state_entry_t states        [N_S]
);

    localparam int E_W = $bits(energy_t);

    for (genvar s = 0; s < N_S; s++) begin : g_state
        energy_t      norm_energy;
        logic [E_W:0] sum_energy;
        energy_t      next_energy;

        // ####################
        // Energy update.
        // ####################

        // The best energy is the minimum of all states, so no wrap here.
        assign norm_energy = states[s].energy - best_energy;

        // One extra bit catches the overflow.
        assign sum_energy = {1'b0, norm_energy} + {1'b0, branch_metric[s]};

        assign next_energy = sum_energy[E_W] ? ENERGY_MAX : sum_energy[E_W-1:0];

        // ####################
        // Survivor entry.
        // ####################

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                states[s] <= '0;
            end else if (run) begin
                states[s].energy <= next_energy;
                states[s].hist   <= new_hist[s];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/rsse_slice_top.sv
`timescale 1ns/1ns
`default_nettype none

module rsse_slice_top
    import rsse_pkg::*;
#(
    parameter int N_S        = 7,
    parameter int H_DEPTH    = 6,
    parameter int SH_DEPTH   = 18,
    parameter int CHAN_DEPTH = 24
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  energy_t    branch_metric          [N_S],
    input  sym_block_t new_hist               [N_S],
    input  sample_t    est_channel            [CHAN_DEPTH],
    input  sample_t    rse_vals               [B_LEN],
    output sym_block_t final_symbols,
    output sample_t    precomputed_static_val [B_LEN],
    output energy_t    global_static_energy
);

    // Survivor bank out, best energy back in.
    state_entry_t states [N_S];
    energy_t      best_energy;

    state_metric_bank #(
        .N_S(N_S)
    ) u_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .branch_metric(branch_metric),
        .new_hist     (new_hist),
        .best_energy  (best_energy),
        .states       (states)
    );

    global_static_unit #(
        .N_S       (N_S),
        .H_DEPTH   (H_DEPTH),
        .SH_DEPTH  (SH_DEPTH),
        .CHAN_DEPTH(CHAN_DEPTH)
    ) u_global (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .run                   (run),
        .states                (states),
        .est_channel           (est_channel),
        .rse_vals              (rse_vals),
        .best_energy           (best_energy),
        .final_symbols         (final_symbols),
        .precomputed_static_val(precomputed_static_val),
        .global_static_energy  (global_static_energy)
    );

endmodule

`default_nettype wire

// File: bench/tb_rsse_model.svh
`ifndef TB_RSSE_MODEL_SVH
`define TB_RSSE_MODEL_SVH

// ####################
// Random source.
// ####################

function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit.
function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// The unused code 2'b10 folds onto zero.
function automatic sym_t rand_symbol();
    logic [1:0] r;
    r = 2'(rand_bits(2));
    return (r == 2'b10) ? sym_t'(0) : sym_t'(r);
endfunction

// ####################
// Reference rules.
// ####################

// Lowest energy wins, lowest index on a tie.
function automatic int best_index();
    int b;
    b = 0;
    for (int s = 1; s < N_S; s++) begin
        if (m_energy[s] < m_energy[b]) begin
            b = s;
        end
    end
    return b;
endfunction

function automatic energy_t saturated_energy(energy_t e, energy_t best, energy_t bm);
    int sum;
    sum = int'(e) - int'(best) + int'(bm);
    return (sum > int'(ENERGY_MAX)) ? ENERGY_MAX : energy_t'(sum);
endfunction

function automatic sample_t static_term(int j);
    int acc;
    int idx;
    acc = 0;
    for (int k = 0; k < CHAN_DEPTH; k++) begin
        idx = k + j - CONV_OFFSET;
        if (idx >= 0 && idx < SH_DEPTH) begin
            acc += int'(m_history[idx]) * int'(est_channel[k]);
        end
    end
    return sample_t'(acc >>> 1);
endfunction

function automatic sym_block_t expected_final();
    sym_block_t f;
    for (int j = 0; j < B_LEN; j++) begin
        f[j] = m_history[j];
    end
    return f;
endfunction

// All of it from the state before the edge.
task automatic apply_run();
    int      b;
    int      ties;
    energy_t b_energy;
    b        = best_index();
    b_energy = m_energy[b];
    ties     = 0;
    // Only a tie between different survivors shows the index rule.
    for (int s = 0; s < N_S; s++) begin
        if (m_energy[s] == b_energy && m_hist[s] != m_hist[b]) ties++;
    end
    if (ties > 0 && b_energy != ENERGY_MAX) tie_runs++;
    for (int i = SH_DEPTH - 1; i >= B_LEN; i--) begin
        m_history[i] = m_history[i-B_LEN];
    end
    for (int j = 0; j < B_LEN; j++) begin
        m_history[j] = m_hist[b][j];
    end
    m_gse = b_energy;
    for (int s = 0; s < N_S; s++) begin
        m_energy[s] = saturated_energy(m_energy[s], b_energy, branch_metric[s]);
        m_hist[s]   = new_hist[s];
        // A full-scale metric lands on the limit by itself.
        if (m_energy[s] == ENERGY_MAX && branch_metric[s] != ENERGY_MAX) sat_runs++;
    end
endtask

`endif

// File: bench/tb_rsse_slice.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rsse_slice
    import rsse_pkg::*;
();

    localparam int N_S          = 7;
    localparam int H_DEPTH      = 6;
    localparam int SH_DEPTH     = 18;
    localparam int CHAN_DEPTH   = 24;
    localparam int CONV_OFFSET  = B_LEN + H_DEPTH + S_LEN;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] SEED = 32'd98164;

    // Stimulus steps per phase.
    localparam int N_START  = 4;
    localparam int N_RANDOM = 200;
    localparam int N_TIE    = 100;
    localparam int N_SAT    = 100;
    localparam int N_IDLE   = 12;
    localparam int N_B2B    = 150;
    localparam int N_TAIL   = 2;
    localparam int NUM_RUNS = N_START + N_RANDOM + N_TIE + N_SAT + N_IDLE + N_B2B + N_TAIL;
    localparam int WATCHDOG_NS = (NUM_RUNS + 64) * CLK_PERIOD * 4;

    localparam int MODE_RANDOM = 0;
    localparam int MODE_TIE    = 1;
    localparam int MODE_SAT    = 2;
    localparam int MODE_MAX    = 3;

    logic       clk;
    logic       rst_n;
    logic       run;
    energy_t    branch_metric          [N_S];
    sym_block_t new_hist               [N_S];
    sample_t    est_channel            [CHAN_DEPTH];
    sample_t    rse_vals               [B_LEN];
    sym_block_t final_symbols;
    sample_t    precomputed_static_val [B_LEN];
    energy_t    global_static_energy;

    // Shadow state of the model.
    energy_t    m_energy  [N_S];
    sym_block_t m_hist    [N_S];
    sym_t       m_history [SH_DEPTH];
    energy_t    m_gse;

    logic [31:0] lfsr_state;
    logic        checking;
    int          err_count;
    int          check_count;
    int          tie_runs;
    int          sat_runs;
    event        compare_done;

    `include "tb_rsse_model.svh"

    rsse_slice_top #(
        .N_S       (N_S),
        .H_DEPTH   (H_DEPTH),
        .SH_DEPTH  (SH_DEPTH),
        .CHAN_DEPTH(CHAN_DEPTH)
    ) UUT (
        .clk                   (clk),
        .rst_n                 (rst_n),
        .run                   (run),
        .branch_metric         (branch_metric),
        .new_hist              (new_hist),
        .est_channel           (est_channel),
        .rse_vals              (rse_vals),
        .final_symbols         (final_symbols),
        .precomputed_static_val(precomputed_static_val),
        .global_static_energy  (global_static_energy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    // ####################
    // Compare.
    // ####################

    // Checks first, then lets the stimulus move on.
    always @(negedge clk) begin
        if (checking) begin
            check_value("final_symbols", 32'(expected_final()), 32'(final_symbols));
            check_value("global_static_energy", 32'(m_gse), 32'(global_static_energy));
            for (int j = 0; j < B_LEN; j++) begin
                check_value($sformatf("precomputed_static_val[%0d]", j),
                            32'(sample_t'(static_term(j) + rse_vals[j])),
                            32'(precomputed_static_val[j]));
            end
        end
        -> compare_done;
    end

    // ####################
    // Stimulus.
    // ####################

    function automatic energy_t pick_metric(int mode);
        case (mode)
            MODE_TIE: return energy_t'(rand_bits(2));
            MODE_SAT: return {1'b1, 15'(rand_bits(15))};
            MODE_MAX: return ENERGY_MAX;
            default:  return energy_t'(rand_bits(12));
        endcase
    endfunction

    task automatic refresh_channel();
        for (int k = 0; k < CHAN_DEPTH; k++) begin
            est_channel[k] = sample_t'(rand_bits(B_WIDTH));
        end
    endtask

    task automatic drive_step(int mode, logic do_run);
        @(compare_done);
        for (int s = 0; s < N_S; s++) begin
            branch_metric[s] = pick_metric(mode);
            new_hist[s][1]   = rand_symbol();
            new_hist[s][0]   = rand_symbol();
        end
        for (int j = 0; j < B_LEN; j++) begin
            rse_vals[j] = sample_t'(rand_bits(B_WIDTH));
        end
        if (rand_bits(4) == 0) refresh_channel();
        run = do_run;
        if (do_run) apply_run();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        checking    = 1'b0;
        lfsr_state  = SEED;
        err_count   = 0;
        check_count = 0;
        tie_runs    = 0;
        sat_runs    = 0;
        m_gse       = '0;
        for (int s = 0; s < N_S; s++) begin
            branch_metric[s] = '0;
            new_hist[s]      = '0;
            m_energy[s]      = '0;
            m_hist[s]        = '0;
        end
        for (int k = 0; k < CHAN_DEPTH; k++) est_channel[k] = '0;
        for (int j = 0; j < B_LEN; j++) rse_vals[j] = '0;
        for (int i = 0; i < SH_DEPTH; i++) m_history[i] = '0;

        repeat (RESET_CYCLES) @(compare_done);
        rst_n    = 1'b1;
        checking = 1'b1;
        refresh_channel();

        // Out of reset the history is zero.
        repeat (N_START) drive_step(MODE_RANDOM, 1'b0);
        repeat (N_RANDOM) drive_step(MODE_RANDOM, rand_bits(1) != 0);
        // One full-scale run levels all energies, so small metrics tie often.
        drive_step(MODE_MAX, 1'b1);
        repeat (N_TIE - 1) drive_step(MODE_TIE, 1'b1);
        for (int i = 0; i < N_SAT; i++) begin
            drive_step((i % 8 == 7) ? MODE_MAX : MODE_SAT, 1'b1);
        end
        // Inputs keep moving while run stays low.
        repeat (N_IDLE) drive_step(MODE_RANDOM, 1'b0);
        repeat (N_B2B) drive_step(MODE_RANDOM, 1'b1);
        repeat (N_TAIL) drive_step(MODE_RANDOM, 1'b0);
        @(compare_done);

        if (tie_runs == 0) begin
            err_count++;
            $display("No run saw two different survivors tied at the minimum energy.");
        end
        if (sat_runs == 0) begin
            err_count++;
            $display("No path energy ever overflowed into the saturation value.");
        end
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // ####################
    // Watchdog.
    // ####################

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence completed.");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
rtl/rsse_pkg.sv
rtl/conv_unit.sv
rtl/static_select_unit.sv
rtl/global_static_unit.sv
rtl/state_metric_bank.sv
rtl/rsse_slice_top.sv
bench/tb_rsse_slice.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the RSSE slice testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_rsse_slice -f sources.f \
    -o tb_rsse_slice \
    && ./obj_dir/tb_rsse_slice > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed."; exit 1; }

cat "$LOG"

grep -q "STATUS: FAIL" "$LOG" \
    && { echo "Simulation reported a failure."; exit 1; } \
    || { echo "Simulation passed."; exit 0; }
